//--- Makefile
TOP := tb_mem_subsys
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f project.f

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ) sim.log

//--- bench/tb_clock.sv
`timescale 1ns/1ps

// 8 ns clock, reset held low for the first 8 cycles
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- bench/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_cmd_pkg::*;

    // fill about 520 cycles plus about 250 directed and 700 random, with wide margin
    localparam int CYCLE_LIMIT  = 4000;
    localparam int RESP_LIMIT   = 4 * MEM_READ_LATENCY + 8;
    localparam int QUIET_CYCLES = MEM_READ_LATENCY + 1;
    localparam int RANDOM_OPS   = 60;

    logic  clk;
    logic  rst_n;
    logic  ireq_valid;
    addr_t ireq_addr;
    logic  ireq_ready;
    logic  iresp_valid;
    addr_t iresp_addr;
    word_t iresp_inst;
    logic  dreq_valid;
    logic  dreq_wen;
    addr_t dreq_addr;
    word_t dreq_wdata;
    logic  dreq_ready;
    logic  dresp_valid;
    addr_t dresp_addr;
    word_t dresp_rdata;

    // expected memory contents
    word_t       ref_mem [MEM_WORDS];
    logic [31:0] rng_state = 32'h8e92e739;

    int    cycle_count = 0;
    int    error_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    errors_at_start = 0;
    int    last_fetch_latency = 0;
    string test_name = "";

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .ireq_ready  (ireq_ready),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_rdata (dresp_rdata)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // word index is the byte address over four wrapped at the depth
    function automatic int ref_index(input addr_t a);
        return int'((a / 4) % addr_t'(MEM_WORDS));
    endfunction

    function automatic word_t fill_pattern(input addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name,
                     error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // hold the request until the shared ready accepts it
    task automatic issue_req(input logic do_i, input addr_t i_addr, input logic do_d,
                             input logic d_wen, input addr_t d_addr, input word_t d_wdata);
        @(posedge clk);
        #1;
        ireq_valid = do_i;
        ireq_addr  = i_addr;
        dreq_valid = do_d;
        dreq_wen   = d_wen;
        dreq_addr  = d_addr;
        dreq_wdata = d_wdata;
        @(negedge clk);
        while (!ireq_ready) begin
            @(negedge clk);
        end
        check_bit("dreq_ready", 1'b1, dreq_ready);
        @(posedge clk);
        #1;
        ireq_valid = 1'b0;
        dreq_valid = 1'b0;
    endtask

    // counts cycles from the accepting edge with mid-cycle sampling
    task automatic collect_resp(input logic want_i, input addr_t i_addr, input word_t exp_i,
                                input logic want_d, input addr_t d_addr, input word_t exp_d,
                                output int i_lat);
        int n;
        int got_i;
        int got_d;
        int d_at;
        n = 0;
        got_i = 0;
        got_d = 0;
        d_at = 0;
        i_lat = 0;
        while (((want_i && got_i == 0) || (want_d && got_d == 0)) && n < RESP_LIMIT) begin
            @(negedge clk);
            n++;
            if (iresp_valid) begin
                if (!want_i || got_i != 0) begin
                    $display("%s: instruction response that no request asked for", test_name);
                    error_count++;
                end else begin
                    i_lat = n;
                    check_addr("iresp_addr", i_addr, iresp_addr);
                    check_word("iresp_inst", exp_i, iresp_inst);
                end
                got_i++;
            end
            if (dresp_valid) begin
                if (!want_d || got_d != 0) begin
                    $display("%s: data response that no request asked for", test_name);
                    error_count++;
                end else begin
                    d_at = n;
                    check_addr("dresp_addr", d_addr, dresp_addr);
                    check_word("dresp_rdata", exp_d, dresp_rdata);
                end
                got_d++;
            end
        end
        if ((want_i && got_i == 0) || (want_d && got_d == 0)) begin
            $display("%s: read response missing after %0d cycles", test_name, RESP_LIMIT);
            error_count++;
        end
        if (want_i && want_d && got_i == 1 && got_d == 1 && i_lat >= d_at) begin
            $display("%s: data response did not come after the instruction response",
                     test_name);
            error_count++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (iresp_valid || dresp_valid) begin
                $display("%s: extra response strobe after the request completed", test_name);
                error_count++;
            end
        end
    endtask

    task automatic run_op(input logic do_i, input addr_t i_addr, input logic do_d,
                          input logic d_wen, input addr_t d_addr, input word_t d_wdata);
        word_t exp_i;
        word_t exp_d;
        int    lat;
        exp_i = ref_mem[ref_index(i_addr)];
        exp_d = ref_mem[ref_index(d_addr)];
        // fetch goes first and sees the word before a write issued with it
        if (do_d && d_wen) begin
            ref_mem[ref_index(d_addr)] = d_wdata;
        end
        issue_req(do_i, i_addr, do_d, d_wen, d_addr, d_wdata);
        collect_resp(do_i, i_addr, exp_i, do_d && !d_wen, d_addr, exp_d, lat);
        last_fetch_latency = lat;
    endtask

    // every word gets a known value before any read
    task automatic fill_memory();
        addr_t a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = addr_t'(i) << 2;
            ref_mem[i] = fill_pattern(a);
            issue_req(1'b0, '0, 1'b1, 1'b1, a, fill_pattern(a));
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge clk);
        check_bit("ireq_ready", 1'b1, ireq_ready);
        check_bit("dreq_ready", 1'b1, dreq_ready);
        check_bit("iresp_valid", 1'b0, iresp_valid);
        check_bit("dresp_valid", 1'b0, dresp_valid);
        end_test();
    endtask

    task automatic test_write_read();
        addr_t a;
        word_t w;
        start_test("write_read");
        repeat (4) begin
            a = next_rand();
            w = next_rand();
            run_op(1'b0, '0, 1'b1, 1'b1, a, w);
            run_op(1'b0, '0, 1'b1, 1'b0, a, '0);
        end
        end_test();
    endtask

    task automatic test_fetch_after_write();
        addr_t a;
        word_t w;
        start_test("fetch_after_write");
        repeat (4) begin
            a = next_rand();
            w = next_rand();
            run_op(1'b0, '0, 1'b1, 1'b1, a, w);
            run_op(1'b1, a, 1'b0, 1'b0, '0, '0);
            check_count("fetch latency", MEM_READ_LATENCY, last_fetch_latency);
        end
        end_test();
    endtask

    task automatic test_fetch_and_read();
        start_test("fetch_and_read");
        repeat (4) begin
            run_op(1'b1, next_rand(), 1'b1, 1'b0, next_rand(), '0);
        end
        end_test();
    endtask

    task automatic test_fetch_and_write();
        addr_t a;
        start_test("fetch_and_write");
        repeat (4) begin
            a = next_rand();
            run_op(1'b1, a, 1'b1, 1'b1, a, next_rand());
            run_op(1'b0, '0, 1'b1, 1'b0, a, '0);
        end
        end_test();
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic        do_i;
        logic        do_d;
        addr_t       ia;
        addr_t       da;
        start_test("random_mix");
        repeat (RANDOM_OPS) begin
            r = next_rand();
            do_i = r[0];
            do_d = r[1] | !r[0];
            // 16 word window with the upper bits aliasing onto it
            ia = next_rand() & 32'hf000_003f;
            da = next_rand() & 32'hf000_003f;
            run_op(do_i, ia, do_d, r[2], da, next_rand());
        end
        end_test();
    endtask

    initial begin
        ireq_valid = 1'b0;
        ireq_addr  = '0;
        dreq_valid = 1'b0;
        dreq_wen   = 1'b0;
        dreq_addr  = '0;
        dreq_wdata = '0;
        @(posedge rst_n);
        test_reset_state();
        fill_memory();
        test_write_read();
        test_fetch_after_write();
        test_fetch_and_read();
        test_fetch_and_write();
        test_random_mix();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- hw/mem_bus_if.sv
`timescale 1ns/1ps

// request channel, arbiter to memory
interface mem_req_if;
    import mem_cmd_pkg::*;

    logic  valid;
    logic  ready;
    logic  wen;
    addr_t addr;
    word_t wdata;

    modport master (
        output valid,
        output wen,
        output addr,
        output wdata,
        input  ready
    );

    modport slave (
        input  valid,
        input  wen,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

// read response channel, memory to arbiter
// no back-pressure, valid is a one-cycle strobe
interface mem_resp_if;
    import mem_cmd_pkg::*;

    logic  valid;
    word_t rdata;

    modport source (
        output valid,
        output rdata
    );

    modport sink (
        input valid,
        input rdata
    );

endinterface

//--- hw/mem_cmd_arbiter.sv
`timescale 1ns/1ps

module mem_cmd_arbiter (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               ireq_valid,
    input  mem_cmd_pkg::addr_t ireq_addr,
    output logic               ireq_ready,

    output logic               iresp_valid,
    output mem_cmd_pkg::addr_t iresp_addr,
    output mem_cmd_pkg::word_t iresp_inst,

    input  logic               dreq_valid,
    input  logic               dreq_wen,
    input  mem_cmd_pkg::addr_t dreq_addr,
    input  mem_cmd_pkg::word_t dreq_wdata,
    output logic               dreq_ready,

    output logic               dresp_valid,
    output mem_cmd_pkg::addr_t dresp_addr,
    output mem_cmd_pkg::word_t dresp_rdata,

    mem_req_if.master          mem_req,
    mem_resp_if.sink           mem_resp
);
    import mem_cmd_pkg::*;

    arb_state_t state;
    arb_state_t state_next;

    // requests saved at the accepting edge
    logic  sireq_valid;
    addr_t sireq_addr;
    logic  sdreq_valid;
    logic  sdreq_wen;
    addr_t sdreq_addr;
    word_t sdreq_wdata;

    logic resp_cycle;
    logic both_saved;
    logic req_ready;
    logic take_new;
    logic chain_dreq;
    logic use_saved;
    logic pick_i;

    // the memory answers the read we are waiting for
    assign resp_cycle = (state == WAIT_READ_VALID) && mem_resp.valid;
    assign both_saved = sireq_valid && sdreq_valid;

    // new requests only where they can be issued right away
    assign req_ready = (state == WAIT_CMD) || (resp_cycle && !both_saved);
    assign take_new  = req_ready && (ireq_valid || dreq_valid);

    // fetch finishing with a data request still saved behind it
    assign chain_dreq = resp_cycle && both_saved;
    assign use_saved  = (state == WAIT_READY) || chain_dreq;

    // instruction side wins whenever it has something pending
    assign pick_i = use_saved ? (sireq_valid && !chain_dreq) : ireq_valid;

    assign ireq_ready = req_ready;
    assign dreq_ready = req_ready;

    always_comb begin
        mem_req.valid = 1'b0;
        mem_req.wen   = 1'b0;
        mem_req.addr  = sdreq_addr;
        mem_req.wdata = sdreq_wdata;
        if (use_saved) begin
            mem_req.valid = pick_i || sdreq_valid;
            mem_req.wen   = !pick_i && sdreq_wen;
            mem_req.addr  = pick_i ? sireq_addr : sdreq_addr;
        end else if (req_ready) begin
            // pass-through of the live requests
            mem_req.valid = ireq_valid || dreq_valid;
            mem_req.wen   = !pick_i && dreq_wen;
            mem_req.addr  = pick_i ? ireq_addr : dreq_addr;
            mem_req.wdata = dreq_wdata;
        end
    end

    always_comb begin
        state_next = state;
        if (mem_req.valid) begin
            if (!mem_req.ready) begin
                state_next = WAIT_READY;
            end else if (!mem_req.wen) begin
                state_next = WAIT_READ_VALID;
            end else begin
                // a write is only issued with nothing left behind it
                state_next = WAIT_CMD;
            end
        end else if (resp_cycle || (state == WAIT_READY)) begin
            state_next = WAIT_CMD;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= WAIT_CMD;
            sireq_valid <= 1'b0;
            sdreq_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (take_new) begin
                sireq_valid <= ireq_valid;
                sdreq_valid <= dreq_valid;
            end else if (chain_dreq) begin
                // data request takes the memory once the fetch is done
                sireq_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_new) begin
            sireq_addr  <= ireq_addr;
            sdreq_wen   <= dreq_wen;
            sdreq_addr  <= dreq_addr;
            sdreq_wdata <= dreq_wdata;
        end
    end

    // response goes to whoever owns the read in flight
    assign iresp_valid = resp_cycle && sireq_valid;
    assign iresp_addr  = sireq_addr;
    assign iresp_inst  = mem_resp.rdata;

    assign dresp_valid = resp_cycle && !sireq_valid;
    assign dresp_addr  = sdreq_addr;
    assign dresp_rdata = mem_resp.rdata;

    // stalled request holds until the memory takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req.valid && !mem_req.ready |=>
            mem_req.valid && $stable(mem_req.addr) &&
            $stable(mem_req.wen) && $stable(mem_req.wdata)
    );

    // each memory response finds a waiting owner and raises exactly one strobe
    a_resp_owned: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_resp.valid |-> (state == WAIT_READ_VALID)
    );

endmodule

//--- hw/mem_cmd_pkg.sv
package mem_cmd_pkg;

    // byte address and word widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // unified memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // cycles from read acceptance to response, two or more
    localparam int MEM_READ_LATENCY = 2;
    localparam int LAT_CNT_W = $clog2(MEM_READ_LATENCY + 1);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // arbiter controller states
    //   WAIT_CMD         idle, new requests go straight to the memory
    //   WAIT_READY       memory busy, saved request is held on the bus
    //   WAIT_READ_VALID  read accepted, waiting for the response strobe
    typedef enum logic [1:0] {
        WAIT_CMD,
        WAIT_READY,
        WAIT_READ_VALID
    } arb_state_t;

endpackage

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic               clk,
    input  logic               rst_n,

    // instruction fetch
    input  logic               ireq_valid,
    input  mem_cmd_pkg::addr_t ireq_addr,
    output logic               ireq_ready,
    output logic               iresp_valid,
    output mem_cmd_pkg::addr_t iresp_addr,
    output mem_cmd_pkg::word_t iresp_inst,

    // data access
    input  logic               dreq_valid,
    input  logic               dreq_wen,
    input  mem_cmd_pkg::addr_t dreq_addr,
    input  mem_cmd_pkg::word_t dreq_wdata,
    output logic               dreq_ready,
    output logic               dresp_valid,
    output mem_cmd_pkg::addr_t dresp_addr,
    output mem_cmd_pkg::word_t dresp_rdata
);

    mem_req_if  mem_req ();
    mem_resp_if mem_resp ();

    mem_cmd_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .ireq_ready  (ireq_ready),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_rdata (dresp_rdata),
        .mem_req     (mem_req.master),
        .mem_resp    (mem_resp.sink)
    );

    unified_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req.slave),
        .resp  (mem_resp.source)
    );

endmodule

//--- hw/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
    input logic        clk,
    input logic        rst_n,
    mem_req_if.slave   req,
    mem_resp_if.source resp
);
    import mem_cmd_pkg::*;

    word_t mem [MEM_WORDS];

    // read in flight and its countdown
    logic                 busy;
    logic [LAT_CNT_W-1:0] count;
    logic [MEM_IDX_W-1:0] req_idx;
    logic [MEM_IDX_W-1:0] rd_idx;

    logic rd_fire;
    logic wr_fire;
    logic rd_done;

    // word index wraps at the memory depth
    assign req_idx = req.addr[MEM_IDX_W+1:2];

    // one read outstanding
    assign req.ready = !busy;

    assign rd_fire = req.valid && req.ready && !req.wen;
    assign wr_fire = req.valid && req.ready && req.wen;

    // last edge of the countdown launches the response
    assign rd_done = busy && (count == LAT_CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            count      <= '0;
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= 1'b0;
            if (rd_fire) begin
                busy  <= 1'b1;
                count <= LAT_CNT_W'(MEM_READ_LATENCY - 1);
            end else if (rd_done) begin
                // strobe and ready rise together
                busy       <= 1'b0;
                count      <= '0;
                resp.valid <= 1'b1;
            end else if (busy) begin
                count <= count - LAT_CNT_W'(1);
            end
        end
    end

    // read address kept for the whole countdown
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_idx <= req_idx;
        end
    end

    // nothing is written while busy so the late read sees the right word
    always_ff @(posedge clk) begin
        if (rd_done) begin
            resp.rdata <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[req_idx] <= req.wdata;
        end
    end

    // a strobe follows its read by exactly the fixed latency
    a_resp_has_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp.valid |-> $past(rd_fire, MEM_READ_LATENCY)
    );

endmodule

//--- project.f
hw/mem_cmd_pkg.sv
hw/mem_bus_if.sv
hw/mem_cmd_arbiter.sv
hw/unified_mem.sv
hw/mem_subsys_top.sv
bench/tb_clock.sv
bench/tb_mem_subsys.sv
